// File: include/lsu_cfg.svh
`ifndef LSU_CFG_SVH
`define LSU_CFG_SVH

// data path width in bits
`define LSU_XLEN 32

// byte address width
`define LSU_AW 32

// data sram depth in words
`define LSU_MEM_WORDS 256

// integer register count
`define LSU_NREG 32

`endif

// File: list.f
+incdir+include
verilog/lsu_pkg.sv
verilog/lsu.sv
verilog/data_sram.sv
verilog/writeback.sv
verilog/lsu_top.sv
tb/tb_lsu_top.sv

// File: run.sh
#!/bin/sh
# build and run the lsu testbench with verilator, from the project root
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f list.f --top-module tb_lsu_top -o sim_lsu > build.log 2>&1
status=$?
if [ $status -ne 0 ]; then
    cat build.log
    echo "verilator build failed with status $status"
    exit 1
fi

./obj_dir/sim_lsu > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Done: errors found" "$LOG"; then
    exit 1
fi
exit 0

// File: tb/lsu_golden.txt
# kind funct3 alu_res rs2 rd wb expected  (kind alu, ld or st; rs2 rd wb decimal, others hex)
# pc is 0x1000 plus 4 per data line
alu 0 12345678 0 1 1 12345678
alu 0 deadbeef 0 2 1 deadbeef
alu 0 000000a5 0 3 1 000000a5
alu 0 00008a7f 0 4 1 00008a7f
st 2 00000100 1 0 0 00000100
ld 2 00000100 0 5 1 12345678
st 0 00000101 3 0 0 00000101
ld 2 00000100 0 5 1 1234a578
st 1 00000102 4 0 0 00000102
ld 2 00000100 0 6 1 8a7fa578
ld 0 00000100 0 7 1 00000078
ld 0 00000101 0 7 1 ffffffa5
ld 0 00000102 0 7 1 0000007f
ld 0 00000103 0 7 1 ffffff8a
ld 4 00000101 0 8 1 000000a5
ld 4 00000103 0 8 1 0000008a
ld 1 00000100 0 9 1 ffffa578
ld 1 00000101 0 9 1 00007fa5
ld 1 00000102 0 9 1 ffff8a7f
ld 1 00000103 0 9 1 0000008a
ld 5 00000100 0 10 1 0000a578
ld 5 00000102 0 10 1 00008a7f
ld 3 00000100 0 10 1 00000000
st 2 00000200 1 0 0 00000200
st 2 00000201 2 0 0 00000201
ld 2 00000200 0 11 1 adbeef78
alu 0 cafef00d 0 0 1 cafef00d
st 2 00000300 0 0 0 00000300
ld 2 00000300 0 12 1 00000000
st 2 00000304 5 0 0 00000304
ld 2 00000304 0 12 1 1234a578
alu 0 55555555 0 13 0 55555555
st 2 00000308 13 0 0 00000308
ld 2 00000308 0 14 1 00000000

// File: tb/tb_lsu_top.sv
`timescale 1ns/1ps
`include "lsu_cfg.svh"

module tb_lsu_top
    import lsu_pkg::*;
();

    localparam int PERIOD = 40;

    // one instruction from the golden file
    typedef struct packed {
        logic                 load;
        logic                 store;
        logic [2:0]           funct3;
        logic [`LSU_XLEN-1:0] alu_res;
        reg_idx_t             rs2;
        reg_idx_t             rd;
        logic                 wb;
        logic [`LSU_XLEN-1:0] expected;
    } golden_t;

    logic     clock;
    logic     reset;
    logic     exu_valid;
    exu_req_t exu_req;
    logic     exu_ready;
    logic     commit_valid;
    commit_t  commit;
    logic     commit_ready;

    golden_t     lines [$];
    commit_t     expect_q [$];
    commit_t     held;
    logic        held_valid;
    logic [31:0] lfsr;
    logic        loaded;
    logic        started;
    int          n_lines;
    int          next_line;
    int          in_flight;   // issued but not yet consumed at commit
    int          n_commits;
    int          value_errors;
    int          protocol_errors;

    lsu_top u_dut (
        .clock        (clock),
        .reset        (reset),
        .exu_valid    (exu_valid),
        .exu_req      (exu_req),
        .exu_ready    (exu_ready),
        .commit_valid (commit_valid),
        .commit       (commit),
        .commit_ready (commit_ready)
    );

    always #(PERIOD / 2) clock = ~clock;

    // taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic read_golden();
        int      fd;
        int      f3;
        int      rs2;
        int      rd;
        int      wb;
        string   text;
        string   kind;
        golden_t g;
        logic [31:0] alu;
        logic [31:0] exp;
        fd = $fopen("tb/lsu_golden.txt", "r");
        if (fd == 0) begin
            $display("cannot open tb/lsu_golden.txt");
            protocol_errors++;
            return;
        end
        while (!$feof(fd)) begin
            if ($fgets(text, fd) != 0) begin
                if ($sscanf(text, "%s %h %h %d %d %d %h",
                            kind, f3, alu, rs2, rd, wb, exp) == 7) begin
                    g.load     = (kind == "ld");
                    g.store    = (kind == "st");
                    g.funct3   = 3'(f3);
                    g.alu_res  = alu;
                    g.rs2      = reg_idx_t'(rs2);
                    g.rd       = reg_idx_t'(rd);
                    g.wb       = (wb != 0);
                    g.expected = exp;
                    if (kind != "alu" && kind != "ld" && kind != "st") begin
                        $display("unknown instruction kind %s in golden file", kind);
                        protocol_errors++;
                    end
                    lines.push_back(g);
                end
            end
        end
        $fclose(fd);
    endtask

    task automatic issue(input golden_t g, input int idx);
        commit_t c;
        exu_valid       = 1'b1;
        exu_req.pc      = `LSU_AW'(32'h1000 + 4 * idx);
        exu_req.load    = g.load;
        exu_req.store   = g.store;
        exu_req.funct3  = g.funct3;
        exu_req.alu_res = g.alu_res;
        exu_req.rs2     = g.rs2;
        exu_req.rd      = g.rd;
        exu_req.wb      = g.wb;
        c.pc    = exu_req.pc;
        c.rd    = g.rd;
        c.wb    = g.wb;
        c.value = g.expected;   // stores carry their address
        expect_q.push_back(c);
    endtask

    task automatic compare_commit(input commit_t got);
        commit_t exp;
        assert (expect_q.size() != 0) else begin
            protocol_errors++;
            $display("commit for pc %h arrived with nothing outstanding", got.pc);
        end
        if (expect_q.size() != 0) begin
            exp = expect_q.pop_front();
            n_commits++;
            assert (got == exp) else begin
                value_errors++;
                $display("FAIL %0t: pc %h rd %0d wb %b value %h, want %h %0d %b %h",
                         $time, got.pc, got.rd, got.wb, got.value,
                         exp.pc, exp.rd, exp.wb, exp.value);
            end
        end
    endtask

    // outputs here are settled since the last rising edge
    always @(negedge clock) begin
        if (started) begin
            assert (!exu_ready || in_flight == (commit_valid ? 1 : 0)) else begin
                protocol_errors++;
                $display("FAIL %0t: exu_ready high with %0d in flight", $time, in_flight);
            end
            if (held_valid) begin
                assert (commit_valid && commit == held) else begin
                    protocol_errors++;
                    $display("FAIL %0t: commit changed while commit_ready was low", $time);
                end
            end
            lfsr = lfsr_step(lfsr);
            commit_ready = lfsr[0];
            held_valid = commit_valid && !commit_ready;
            held = commit;
            if (commit_valid && commit_ready) begin
                compare_commit(commit);   // consumed on the coming edge
                in_flight--;
            end
            if (exu_ready && next_line < n_lines) begin
                issue(lines[next_line], next_line);
                next_line++;
                in_flight++;
            end else begin
                exu_valid = 1'b0;
            end
        end
    end

    initial begin
        clock           = 1'b0;
        reset           = 1'b1;
        exu_valid       = 1'b0;
        exu_req         = '0;
        commit_ready    = 1'b0;
        lfsr            = 32'he25e;
        held_valid      = 1'b0;
        held            = '0;
        loaded          = 1'b0;
        started         = 1'b0;
        next_line       = 0;
        in_flight       = 0;
        n_commits       = 0;
        value_errors    = 0;
        protocol_errors = 0;
        read_golden();
        n_lines = lines.size();
        loaded = 1'b1;
        repeat (4) @(posedge clock);
        started = 1'b1;
        @(negedge clock);
        reset = 1'b0;
        assert (exu_ready && !commit_valid) else begin
            protocol_errors++;
            $display("FAIL %0t: after reset exu_ready=%b commit_valid=%b",
                     $time, exu_ready, commit_valid);
        end
        wait (next_line == n_lines && in_flight == 0);
        @(negedge clock);
        assert (n_lines > 0 && n_commits == n_lines) else begin
            protocol_errors++;
            $display("only %0d of %0d instructions committed", n_commits, n_lines);
        end
        $display("commits %0d of %0d, value errors %0d, protocol errors %0d",
                 n_commits, n_lines, value_errors, protocol_errors);
        if (value_errors == 0 && protocol_errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

    // a few cycles per instruction plus stalls
    initial begin
        wait (loaded);
        repeat (n_lines * 40 + 20) @(posedge clock);
        $display("timeout: %0d of %0d commits, value errors %0d, protocol errors %0d",
                 n_commits, n_lines, value_errors, protocol_errors);
        $display("Done: errors found");
        $finish;
    end

endmodule

// File: verilog/data_sram.sv
`timescale 1ns/1ps
`include "lsu_cfg.svh"

module data_sram
    import lsu_pkg::*;
(
    input  logic     clock,
    input  logic     reset,
    input  axi_req_t axi_req,
    output axi_rsp_t axi_rsp
);

    localparam int LANES = `LSU_XLEN / 8;
    localparam int OFF_W = $clog2(LANES);
    localparam int IDX_W = $clog2(`LSU_MEM_WORDS);

    logic [`LSU_XLEN-1:0] mem [`LSU_MEM_WORDS];

    logic                 rvalid;
    logic                 bvalid;
    logic [`LSU_XLEN-1:0] rdata;

    logic             busy;
    logic             ar_fire;
    logic             w_fire;
    logic [IDX_W-1:0] rd_idx;
    logic [IDX_W-1:0] wr_idx;

    assign busy    = rvalid || bvalid;   // one response outstanding at most
    assign ar_fire = axi_req.arvalid && !busy;
    assign w_fire  = axi_req.awvalid && axi_req.wvalid && !busy;

    // upper address bits dropped so accesses wrap
    assign rd_idx = axi_req.araddr[OFF_W +: IDX_W];
    assign wr_idx = axi_req.awaddr[OFF_W +: IDX_W];

    always_ff @(posedge clock) begin
        if (reset) begin
            rvalid <= 1'b0;
            bvalid <= 1'b0;
        end else begin
            if (ar_fire) begin
                rvalid <= 1'b1;
            end else if (axi_req.rready) begin
                rvalid <= 1'b0;
            end
            if (w_fire) begin
                bvalid <= 1'b1;
            end else if (axi_req.bready) begin
                bvalid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (ar_fire) begin
            rdata <= mem[rd_idx];   // full word for the lsu to align
        end
    end

    always_ff @(posedge clock) begin
        if (w_fire) begin
            for (int b = 0; b < LANES; b++) begin
                if (axi_req.wstrb[b]) begin
                    mem[wr_idx][8*b +: 8] <= axi_req.wdata[8*b +: 8];
                end
            end
        end
    end

    always_comb begin
        axi_rsp.arready = !busy;
        axi_rsp.awready = !busy;
        axi_rsp.wready  = !busy;
        axi_rsp.rvalid  = rvalid;
        axi_rsp.rdata   = rdata;
        axi_rsp.bvalid  = bvalid;
    end

    a_rsp_exclusive: assert property (@(posedge clock) disable iff (reset)
        !(axi_rsp.rvalid && axi_rsp.bvalid));

endmodule

// File: verilog/lsu.sv
`timescale 1ns/1ps
`include "lsu_cfg.svh"

module lsu
    import lsu_pkg::*;
(
    input  logic                 clock,
    input  logic                 reset,
    input  logic                 exu_valid,
    input  exu_req_t             exu_req,
    output logic                 exu_ready,
    output reg_idx_t             rf_raddr,
    input  logic [`LSU_XLEN-1:0] rf_rdata,
    output axi_req_t             axi_req,
    input  axi_rsp_t             axi_rsp,
    output logic                 wbu_valid,
    output wbu_req_t             wbu_req,
    input  logic                 wbu_ready
);

    localparam int LANES = `LSU_XLEN / 8;
    localparam int OFF_W = $clog2(LANES);

    lsu_state_t state;

    logic ar_valid;
    logic r_ready;
    logic aw_valid;
    logic w_valid;
    logic b_ready;

    logic [`LSU_AW-1:0]   addr;
    logic [2:0]           size;
    logic [`LSU_XLEN-1:0] wdata;
    logic [LANES-1:0]     wstrb;
    logic [OFF_W-1:0]     ld_off;
    logic [2:0]           ld_funct3;

    logic             take;
    logic             mem_op;
    logic             rsp_seen;
    logic [OFF_W-1:0] off;

    // byte lanes touched by SB / SH / SW before shifting
    function automatic logic [LANES-1:0] store_strb(input logic [1:0] width);
        case (width)
            2'b00:   store_strb = {{(LANES-1){1'b0}}, 1'b1};
            2'b01:   store_strb = {{(LANES-2){1'b0}}, 2'b11};
            2'b10:   store_strb = '1;
            default: store_strb = '0;
        endcase
    endfunction

    function automatic logic [`LSU_XLEN-1:0] load_extend(
        input logic [`LSU_XLEN-1:0] rdata,
        input logic [OFF_W-1:0]     lane,
        input logic [2:0]           funct3
    );
        logic [`LSU_XLEN-1:0] data;
        data = rdata >> {lane, 3'b000};
        case (funct3)
            3'b000:  load_extend = {{(`LSU_XLEN-8){data[7]}}, data[7:0]};      // lb
            3'b001:  load_extend = {{(`LSU_XLEN-16){data[15]}}, data[15:0]};   // lh
            3'b010:  load_extend = data;                                       // lw
            3'b100:  load_extend = {{(`LSU_XLEN-8){1'b0}}, data[7:0]};         // lbu
            3'b101:  load_extend = {{(`LSU_XLEN-16){1'b0}}, data[15:0]};       // lhu
            default: load_extend = '0;
        endcase
    endfunction

    assign take     = (state == IDLE) && exu_valid;
    assign mem_op   = exu_req.load || exu_req.store;
    assign rsp_seen = axi_rsp.rvalid || axi_rsp.bvalid;
    assign off      = exu_req.alu_res[OFF_W-1:0];
    assign rf_raddr = exu_req.rs2;

    always_ff @(posedge clock) begin
        if (reset) begin
            state     <= IDLE;
            exu_ready <= 1'b1;
            wbu_valid <= 1'b0;
            ar_valid  <= 1'b0;
            r_ready   <= 1'b0;
            aw_valid  <= 1'b0;
            w_valid   <= 1'b0;
            b_ready   <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    if (exu_valid) begin
                        exu_ready <= 1'b0;
                        if (mem_op) begin
                            state    <= EXEC;
                            ar_valid <= exu_req.load;
                            aw_valid <= exu_req.store && !exu_req.load;   // aw and w go up together
                            w_valid  <= exu_req.store && !exu_req.load;
                        end else begin
                            state     <= WAIT;   // bypass
                            wbu_valid <= 1'b1;
                        end
                    end
                end
                EXEC: begin
                    if (axi_rsp.arready) ar_valid <= 1'b0;
                    if (axi_rsp.awready) aw_valid <= 1'b0;
                    if (axi_rsp.wready) w_valid <= 1'b0;
                    if (axi_rsp.rvalid) r_ready <= 1'b1;
                    if (axi_rsp.bvalid) b_ready <= 1'b1;
                    if (rsp_seen) begin
                        state     <= WAIT;
                        wbu_valid <= 1'b1;
                    end
                end
                WAIT: begin
                    r_ready <= 1'b0;   // response beat taken on first wait edge
                    b_ready <= 1'b0;
                    if (wbu_ready) begin
                        state     <= IDLE;
                        wbu_valid <= 1'b0;
                        exu_ready <= 1'b1;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (take) begin
            addr           <= exu_req.alu_res[`LSU_AW-1:0];
            size           <= {1'b0, exu_req.funct3[1:0]};
            wdata          <= rf_rdata << {off, 3'b000};
            wstrb          <= store_strb(exu_req.funct3[1:0]) << off;
            ld_off         <= off;
            ld_funct3      <= exu_req.funct3;
            wbu_req.pc     <= exu_req.pc;
            wbu_req.rd     <= exu_req.rd;
            wbu_req.wb     <= exu_req.wb;
            wbu_req.result <= exu_req.alu_res;   // stores keep the address
        end else if (state == EXEC && axi_rsp.rvalid) begin
            wbu_req.result <= load_extend(axi_rsp.rdata, ld_off, ld_funct3);
        end
    end

    always_comb begin
        axi_req.arvalid = ar_valid;
        axi_req.araddr  = addr;
        axi_req.arsize  = size;
        axi_req.rready  = r_ready;
        axi_req.awvalid = aw_valid;
        axi_req.awaddr  = addr;
        axi_req.awsize  = size;
        axi_req.wvalid  = w_valid;
        axi_req.wdata   = wdata;
        axi_req.wstrb   = wstrb;
        axi_req.bready  = b_ready;
    end

    a_no_overlap: assert property (@(posedge clock) disable iff (reset)
        !(exu_ready && wbu_valid));

    a_one_channel: assert property (@(posedge clock) disable iff (reset)
        !(axi_req.arvalid && axi_req.awvalid));

    // read address must hold until the slave takes it
    a_ar_stable: assert property (@(posedge clock) disable iff (reset)
        axi_req.arvalid && !axi_rsp.arready |=> $stable(axi_req));

endmodule

// File: verilog/lsu_pkg.sv
`include "lsu_cfg.svh"

package lsu_pkg;

    typedef logic [$clog2(`LSU_NREG)-1:0] reg_idx_t;

    typedef enum logic [1:0] {
        IDLE,
        EXEC,
        WAIT
    } lsu_state_t;

    typedef struct packed {
        logic [`LSU_AW-1:0]   pc;
        logic                 load;
        logic                 store;
        logic [2:0]           funct3;
        logic [`LSU_XLEN-1:0] alu_res;   // result, or address for load/store
        reg_idx_t             rs2;       // store data register
        reg_idx_t             rd;
        logic                 wb;
    } exu_req_t;

    typedef struct packed {
        logic [`LSU_AW-1:0]   pc;
        reg_idx_t             rd;
        logic                 wb;
        logic [`LSU_XLEN-1:0] result;
    } wbu_req_t;

    typedef struct packed {
        logic [`LSU_AW-1:0]   pc;
        reg_idx_t             rd;
        logic                 wb;
        logic [`LSU_XLEN-1:0] value;
    } commit_t;

    // master side of a single-beat port
    typedef struct packed {
        logic                   arvalid;
        logic [`LSU_AW-1:0]     araddr;
        logic [2:0]             arsize;
        logic                   rready;
        logic                   awvalid;
        logic [`LSU_AW-1:0]     awaddr;
        logic [2:0]             awsize;
        logic                   wvalid;
        logic [`LSU_XLEN-1:0]   wdata;
        logic [`LSU_XLEN/8-1:0] wstrb;
        logic                   bready;
    } axi_req_t;

    typedef struct packed {
        logic                 arready;
        logic                 awready;
        logic                 wready;
        logic                 rvalid;
        logic [`LSU_XLEN-1:0] rdata;
        logic                 bvalid;
    } axi_rsp_t;

endpackage

// File: verilog/lsu_top.sv
`timescale 1ns/1ps
`include "lsu_cfg.svh"

module lsu_top
    import lsu_pkg::*;
(
    input  logic     clock,
    input  logic     reset,
    input  logic     exu_valid,
    input  exu_req_t exu_req,
    output logic     exu_ready,
    output logic     commit_valid,
    output commit_t  commit,
    input  logic     commit_ready
);

    axi_req_t             axi_req;
    axi_rsp_t             axi_rsp;
    reg_idx_t             rf_raddr;
    logic [`LSU_XLEN-1:0] rf_rdata;
    logic                 wbu_valid;
    wbu_req_t             wbu_req;
    logic                 wbu_ready;

    lsu u_lsu (
        .clock     (clock),
        .reset     (reset),
        .exu_valid (exu_valid),
        .exu_req   (exu_req),
        .exu_ready (exu_ready),
        .rf_raddr  (rf_raddr),
        .rf_rdata  (rf_rdata),
        .axi_req   (axi_req),
        .axi_rsp   (axi_rsp),
        .wbu_valid (wbu_valid),
        .wbu_req   (wbu_req),
        .wbu_ready (wbu_ready)
    );

    data_sram u_sram (
        .clock   (clock),
        .reset   (reset),
        .axi_req (axi_req),
        .axi_rsp (axi_rsp)
    );

    writeback u_wb (
        .clock        (clock),
        .reset        (reset),
        .wbu_valid    (wbu_valid),
        .wbu_req      (wbu_req),
        .wbu_ready    (wbu_ready),
        .rf_raddr     (rf_raddr),
        .rf_rdata     (rf_rdata),
        .commit_valid (commit_valid),
        .commit       (commit),
        .commit_ready (commit_ready)
    );

endmodule

// File: verilog/writeback.sv
`timescale 1ns/1ps
`include "lsu_cfg.svh"

module writeback
    import lsu_pkg::*;
(
    input  logic                 clock,
    input  logic                 reset,
    input  logic                 wbu_valid,
    input  wbu_req_t             wbu_req,
    output logic                 wbu_ready,
    input  reg_idx_t             rf_raddr,
    output logic [`LSU_XLEN-1:0] rf_rdata,
    output logic                 commit_valid,
    output commit_t              commit,
    input  logic                 commit_ready
);

    logic [`LSU_XLEN-1:0] rf [`LSU_NREG];
    logic                 wbu_fire;

    assign wbu_ready = !commit_valid || commit_ready;   // slot empty or draining
    assign wbu_fire  = wbu_valid && wbu_ready;

    assign rf_rdata = (rf_raddr == '0) ? '0 : rf[rf_raddr];   // x0 reads zero

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < `LSU_NREG; i++) begin
                rf[i] <= '0;
            end
        end else if (wbu_fire && wbu_req.wb && wbu_req.rd != '0) begin
            rf[wbu_req.rd] <= wbu_req.result;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            commit_valid <= 1'b0;
        end else if (wbu_fire) begin
            commit_valid <= 1'b1;
        end else if (commit_ready) begin
            commit_valid <= 1'b0;
        end
    end

    always_ff @(posedge clock) begin
        if (wbu_fire) begin
            commit.pc    <= wbu_req.pc;
            commit.rd    <= wbu_req.rd;
            commit.wb    <= wbu_req.wb;
            commit.value <= wbu_req.result;
        end
    end

    a_commit_hold: assert property (@(posedge clock) disable iff (reset)
        commit_valid && !commit_ready |=> commit_valid && $stable(commit));

endmodule
